/* logic/ahb_ram_settings.svh */
`ifndef AHB_RAM_SETTINGS_SVH
`define AHB_RAM_SETTINGS_SVH

// Word address bits of each byte lane.
`define RAM_ADDR_WIDTH 6

// Lowest HADDR bit of the word address.
`define RAM_ADDR_LSB 2

`endif

/* logic/ahb_pkg.sv */
`default_nettype none

`include "ahb_ram_settings.svh"

package ahb_pkg;

    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Only sizes up to the bus width are decoded.
    typedef enum logic [2:0]
    {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    typedef enum logic
    {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    typedef struct packed
    {
        logic                          valid;
        logic                          write;
        logic [`RAM_ADDR_WIDTH - 1:0]  addr;
        logic [3:0]                    mask;
    } ahb_phase_t;

endpackage

`default_nettype wire

/* logic/ram_pkg.sv */
`default_nettype none

`include "ahb_ram_settings.svh"

package ram_pkg;

    // One enable bit per byte lane.
    typedef struct packed
    {
        logic [3:0]                    mask;
        logic [`RAM_ADDR_WIDTH - 1:0]  addr;
        logic [31:0]                   data;
    } ram_wr_t;

    typedef struct packed
    {
        logic [`RAM_ADDR_WIDTH - 1:0]  addr;
    } ram_rd_t;

endpackage

`default_nettype wire

/* logic/dual_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ahb_ram_settings.svh"

module dual_port_ram
#(
    parameter int DATA_WIDTH = 8,
    parameter int ADDR_WIDTH = `RAM_ADDR_WIDTH
)
(
    input  wire logic                    HCLK,
    input  wire logic [ADDR_WIDTH - 1:0] read_addr,
    input  wire logic [ADDR_WIDTH - 1:0] write_addr,
    input  wire logic [DATA_WIDTH - 1:0] write_data,
    input  wire logic                    write_enable,
    output logic      [DATA_WIDTH - 1:0] read_data
);

    logic [DATA_WIDTH - 1:0] mem [2**ADDR_WIDTH];

    // Read returns the old word when both ports hit the same address.
    always_ff @(posedge HCLK)
    begin
        if (write_enable)
            mem[write_addr] <= write_data;
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

/* logic/ahb_addr_phase.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ahb_ram_settings.svh"

module ahb_addr_phase
(
    input  wire logic             HCLK,
    input  wire logic             HRESETn,
    input  wire logic             hsel,
    input  wire logic [31:0]      haddr,
    input  wire ahb_pkg::htrans_t htrans,
    input  wire logic             hwrite,
    input  wire ahb_pkg::hsize_t  hsize,
    input  wire logic             hready,
    output ahb_pkg::ahb_phase_t   cur_phase,
    output ahb_pkg::ahb_phase_t   reg_phase,
    output ram_pkg::ram_rd_t      rd_req
);

    import ahb_pkg::*;

    logic                         valid;
    logic [3:0]                   mask;
    logic [`RAM_ADDR_WIDTH - 1:0] word_addr;

    assign valid     = hsel && (htrans == NONSEQ || htrans == SEQ);
    assign word_addr = haddr[`RAM_ADDR_LSB +: `RAM_ADDR_WIDTH];

    // Lanes follow little-endian byte order.
    always_comb
    begin
        mask = 4'b0000;
        if (valid && hwrite)
        begin
            case (hsize)
                BYTE:    mask = 4'b0001 << haddr[1:0];
                HALF:    mask = haddr[1] ? 4'b1100 : 4'b0011;
                default: mask = 4'b1111;
            endcase
        end
    end

    always_comb
    begin
        cur_phase.valid = valid;
        cur_phase.write = hwrite;
        cur_phase.addr  = word_addr;
        cur_phase.mask  = mask;
    end

    // During a stall the RAM re-reads the held read's word.
    always_comb
    begin
        rd_req.addr = hready ? word_addr : reg_phase.addr;
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            reg_phase <= '0;
        else if (hready)
            reg_phase <= cur_phase;
    end

    // Accepted transfers must be naturally aligned.
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (valid && hready && hsize == HALF) |-> !haddr[0]);

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (valid && hready && hsize == WORD) |-> haddr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/ahb_data_phase.sv */
`timescale 1ns/10ps
`default_nettype none

module ahb_data_phase
(
    input  wire logic                HCLK,
    input  wire logic                HRESETn,
    input  wire ahb_pkg::ahb_phase_t cur_phase,
    input  wire ahb_pkg::ahb_phase_t reg_phase,
    input  wire logic [31:0]         hwdata,
    output ram_pkg::ram_wr_t         wr_req,
    output logic                     hready
);

    logic wr_active;
    logic raw_hazard;

    assign wr_active = reg_phase.valid && reg_phase.write;

    // Write data arrives in this phase, so the request is combinational.
    always_comb
    begin
        wr_req.mask = wr_active ? reg_phase.mask : 4'b0000;
        wr_req.addr = reg_phase.addr;
        wr_req.data = hwdata;
    end

    // A read of the word being written now would see stale RAM data.
    assign raw_hazard = cur_phase.valid
                     && !cur_phase.write
                     && wr_active
                     && cur_phase.addr == reg_phase.addr;

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            hready <= 1'b1;
        else
            hready <= !raw_hazard;
    end

    // The stalled phase is a read, so it cannot cause another stall.
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        !hready |=> hready);

endmodule

`default_nettype wire

/* logic/ahb_ram_slave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ahb_ram_settings.svh"

module ahb_ram_slave
(
    input  wire logic             HCLK,
    input  wire logic             HRESETn,
    input  wire logic             hsel,
    input  wire logic [31:0]      haddr,
    input  wire logic [2:0]       hburst,
    input  wire logic             hmastlock,
    input  wire logic [3:0]       hprot,
    input  wire ahb_pkg::htrans_t htrans,
    input  wire logic             hwrite,
    input  wire ahb_pkg::hsize_t  hsize,
    input  wire logic [31:0]      hwdata,
    output wire logic [31:0]      hrdata,
    output wire logic             hready,
    output wire logic             hresp
);

    import ahb_pkg::*;
    import ram_pkg::*;

    ahb_phase_t cur_phase;
    ahb_phase_t reg_phase;
    ram_rd_t    rd_req;
    ram_wr_t    wr_req;

    // Burst, protection and lock carry no meaning for this memory.
    assign hresp = OKAY;

    ahb_addr_phase u_addr_phase
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hready    (hready),
        .cur_phase (cur_phase),
        .reg_phase (reg_phase),
        .rd_req    (rd_req)
    );

    ahb_data_phase u_data_phase
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .cur_phase (cur_phase),
        .reg_phase (reg_phase),
        .hwdata    (hwdata),
        .wr_req    (wr_req),
        .hready    (hready)
    );

    for (genvar i = 0; i < 4; i++)
    begin : g_lane
        dual_port_ram
        #(
            .DATA_WIDTH (8),
            .ADDR_WIDTH (`RAM_ADDR_WIDTH)
        )
        u_ram
        (
            .HCLK         (HCLK),
            .read_addr    (rd_req.addr),
            .write_addr   (wr_req.addr),
            .write_data   (wr_req.data[i * 8 +: 8]),
            .write_enable (wr_req.mask[i]),
            .read_data    (hrdata[i * 8 +: 8])
        );
    end

endmodule

`default_nettype wire

/* tb/tb_ahb_ram_table.svh */
`ifndef TB_AHB_RAM_TABLE_SVH
`define TB_AHB_RAM_TABLE_SVH

    // Each row holds the test name, then kind, size, address, write data and expected stall.
    // Write data sits in the byte lanes that the address selects.
    localparam int NUM_ROWS = 28;

    test_t table_rows [NUM_ROWS] = '{
        '{"word write 0x10", '{op_write, WORD, 32'h0000_0010, 32'h1122_3344, 1'b0}},
        '{"word write 0x14", '{op_write, WORD, 32'h0000_0014, 32'ha5a5_0f0f, 1'b0}},
        '{"word write 0x18", '{op_write, WORD, 32'h0000_0018, 32'hdead_beef, 1'b0}},
        '{"word read 0x10", '{op_read, WORD, 32'h0000_0010, 32'h0000_0000, 1'b0}},
        '{"word read 0x14", '{op_read, WORD, 32'h0000_0014, 32'h0000_0000, 1'b0}},
        '{"word read 0x18", '{op_read, WORD, 32'h0000_0018, 32'h0000_0000, 1'b0}},
        '{"fill word read 0x40", '{op_read, WORD, 32'h0000_0040, 32'h0000_0000, 1'b0}},
        '{"byte write lane 0", '{op_write, BYTE, 32'h0000_0020, 32'h0000_0011, 1'b0}},
        '{"byte write lane 2", '{op_write, BYTE, 32'h0000_0022, 32'h0033_0000, 1'b0}},
        '{"byte write lane 1", '{op_write, BYTE, 32'h0000_0025, 32'h0000_2200, 1'b0}},
        '{"byte write lane 3", '{op_write, BYTE, 32'h0000_0027, 32'h4400_0000, 1'b0}},
        '{"half write low", '{op_write, HALF, 32'h0000_0028, 32'h0000_5566, 1'b0}},
        '{"half write high", '{op_write, HALF, 32'h0000_002e, 32'h7788_0000, 1'b0}},
        '{"merge read 0x20", '{op_read, WORD, 32'h0000_0020, 32'h0000_0000, 1'b0}},
        '{"merge read 0x24", '{op_read, WORD, 32'h0000_0024, 32'h0000_0000, 1'b0}},
        '{"merge read 0x28", '{op_read, WORD, 32'h0000_0028, 32'h0000_0000, 1'b0}},
        '{"merge read 0x2c", '{op_read, WORD, 32'h0000_002c, 32'h0000_0000, 1'b0}},
        '{"hazard word write 0x34", '{op_write, WORD, 32'h0000_0034, 32'hcafe_f00d, 1'b0}},
        '{"hazard word read 0x34", '{op_read, WORD, 32'h0000_0034, 32'h0000_0000, 1'b1}},
        '{"hazard byte write 0x39", '{op_write, BYTE, 32'h0000_0039, 32'h0000_ab00, 1'b0}},
        '{"hazard word read 0x38", '{op_read, WORD, 32'h0000_0038, 32'h0000_0000, 1'b1}},
        '{"write other word 0x3c", '{op_write, WORD, 32'h0000_003c, 32'h0bad_cafe, 1'b0}},
        '{"read other word 0x10", '{op_read, WORD, 32'h0000_0010, 32'h0000_0000, 1'b0}},
        '{"idle write 0x10", '{op_idle, WORD, 32'h0000_0010, 32'hffff_ffff, 1'b0}},
        '{"unselected write 0x14", '{op_nosel, WORD, 32'h0000_0014, 32'hffff_ffff, 1'b0}},
        '{"read after idle 0x10", '{op_read, WORD, 32'h0000_0010, 32'h0000_0000, 1'b0}},
        '{"read after unselected 0x14", '{op_read, WORD, 32'h0000_0014, 32'h0000_0000, 1'b0}},
        '{"half read 0x2e", '{op_read, HALF, 32'h0000_002e, 32'h0000_0000, 1'b0}}
    };

`endif

/* tb/tb_ahb_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ahb_ram_settings.svh"

module tb_ahb_ram;

    import ahb_pkg::*;

    localparam int WORDS        = 2 ** `RAM_ADDR_WIDTH;
    localparam int RESET_CYCLES = 4;

    typedef enum logic [1:0]
    {
        op_write,
        op_read,
        op_idle,
        op_nosel
    } op_t;

    typedef struct packed
    {
        op_t         op;
        hsize_t      size;
        logic [31:0] addr;
        logic [31:0] data;
        logic        stall;
    } row_t;

    typedef struct
    {
        string name;
        row_t  stim;
    } test_t;

    `include "tb_ahb_ram_table.svh"

    // Three cycles for every issued transfer leave room for a stall in each.
    localparam int MAX_CYCLES = 3 * (WORDS + NUM_ROWS + 2) + RESET_CYCLES;

    logic        HCLK;
    logic        HRESETn;
    logic        hsel;
    logic [31:0] haddr;
    logic [2:0]  hburst;
    logic        hmastlock;
    logic [3:0]  hprot;
    htrans_t     htrans;
    logic        hwrite;
    hsize_t      hsize;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;

    logic [31:0] model_mem [WORDS];
    row_t        pend_row;
    string       pend_name;
    logic        pend_valid;
    logic        pend_report;
    int          stall_count;
    int          error_count;
    int          test_count;
    int          cycle_count;
    int          seed;

    ahb_ram_slave u_dut
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hsel      (hsel),
        .haddr     (haddr),
        .hburst    (hburst),
        .hmastlock (hmastlock),
        .hprot     (hprot),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hsize     (hsize),
        .hwdata    (hwdata),
        .hrdata    (hrdata),
        .hready    (hready),
        .hresp     (hresp)
    );

    always #2 HCLK = ~HCLK;

    // Bytes from the offset up to the transfer size take part.
    function automatic logic [31:0] byte_lanes(input hsize_t size, input logic [1:0] offset);
        logic [31:0] lanes;
        int          first;
        int          count;
        lanes = '0;
        first = int'(offset);
        count = 1 << int'(size);
        for (int b = 0; b < 4; b++)
        begin
            if (b >= first && b < first + count)
                lanes[8 * b +: 8] = 8'hff;
        end
        return lanes;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("Error: %s is 0x%08h, expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic finish_data_phase();
        logic [31:0]                  lanes;
        logic [`RAM_ADDR_WIDTH - 1:0] word;
        int                           errors_before;
        errors_before = error_count;
        lanes = byte_lanes(pend_row.size, pend_row.addr[1:0]);
        word  = pend_row.addr[`RAM_ADDR_LSB +: `RAM_ADDR_WIDTH];
        if (pend_row.op == op_write)
            model_mem[word] = (model_mem[word] & ~lanes) | (pend_row.data & lanes);
        else if (pend_row.op == op_read)
            check_value("hrdata", hrdata & lanes, model_mem[word] & lanes);
        check_value("hready low cycles", 32'(stall_count), 32'(pend_row.stall));
        if (pend_report)
        begin
            test_count++;
            if (error_count == errors_before)
                $display("%s: ok", pend_name);
            else
                $display("%s: mismatch", pend_name);
        end
    endtask

    // Drives one address phase and completes the data phase before it.
    task automatic issue(input row_t r, input string name, input logic report);
        @(negedge HCLK);
        hsel   = (r.op != op_nosel);
        haddr  = r.addr;
        hwrite = (r.op != op_read);
        hsize  = r.size;
        if (r.op == op_idle)
            htrans = IDLE;
        else
            htrans = NONSEQ;
        hwdata = pend_valid ? pend_row.data : 32'h0;
        stall_count = 0;
        while (!hready)
        begin
            stall_count++;
            @(negedge HCLK);
        end
        if (pend_valid)
            finish_data_phase();
        pend_valid  = 1'b1;
        pend_row    = r;
        pend_name   = name;
        pend_report = report;
    endtask

    always @(negedge HCLK)
    begin
        if (HRESETn)
            check_value("hresp", 32'(hresp), 32'(OKAY));
    end

    always @(posedge HCLK)
    begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES)
        begin
            $display("Timeout: the transfers did not finish within %0d cycles.", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial
    begin
        row_t fill_row;
        row_t idle_row;
        int   errors_before;
        HCLK        = 1'b0;
        HRESETn     = 1'b0;
        hsel        = 1'b0;
        haddr       = '0;
        hburst      = '0;
        hmastlock   = 1'b0;
        hprot       = 4'b0011;
        htrans      = IDLE;
        hwrite      = 1'b0;
        hsize       = WORD;
        hwdata      = '0;
        seed        = 32'h747d_852a;
        pend_valid  = 1'b0;
        pend_report = 1'b0;
        stall_count = 0;
        error_count = 0;
        test_count  = 0;
        cycle_count = 0;

        repeat (RESET_CYCLES) @(negedge HCLK);
        HRESETn = 1'b1;
        errors_before = error_count;
        check_value("hready", 32'(hready), 32'h1);
        test_count++;
        if (error_count == errors_before)
            $display("reset state: ok");
        else
            $display("reset state: mismatch");

        // Every word gets known random contents before the table runs.
        for (int w = 0; w < WORDS; w++)
        begin
            fill_row.op    = op_write;
            fill_row.size  = WORD;
            fill_row.addr  = 32'(w) << `RAM_ADDR_LSB;
            fill_row.data  = $random(seed);
            fill_row.stall = 1'b0;
            issue(fill_row, "fill", 1'b0);
        end

        for (int i = 0; i < NUM_ROWS; i++)
            issue(table_rows[i].stim, table_rows[i].name, 1'b1);

        idle_row = '{op_idle, WORD, 32'h0, 32'h0, 1'b0};
        issue(idle_row, "flush", 1'b0);

        $display("Tests: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
+incdir+tb
logic/ahb_pkg.sv
logic/ram_pkg.sv
logic/dual_port_ram.sv
logic/ahb_addr_phase.sv
logic/ahb_data_phase.sv
logic/ahb_ram_slave.sv
tb/tb_ahb_ram.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_ahb_ram
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

SOURCES := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard logic/*.svh tb/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
